// ==== logic/ecc_pkg.sv ====
`default_nettype none

package ecc_pkg;

    localparam int DATA_WIDTH   = 36;
    localparam int PARITY_WIDTH = 7;
    localparam int CODE_WIDTH   = DATA_WIDTH + PARITY_WIDTH;
    localparam int ADDR_WIDTH   = 6;
    localparam int MEM_DEPTH    = 2 ** ADDR_WIDTH;
    localparam int COUNT_WIDTH  = 16;

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [PARITY_WIDTH-1:0] parity_t;
    typedef logic [CODE_WIDTH-1:0]   code_t;
    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [COUNT_WIDTH-1:0]  count_t;

    // syndrome produced by a flip of each data bit, indexed by data bit.
    // All columns have odd weight, so a double flip never looks like a single one.
    localparam parity_t check_col [DATA_WIDTH] = '{
        7'b1000011,
        7'b1000101,
        7'b1000110,
        7'b0000111,
        7'b1001001,
        7'b1001010,
        7'b0001011,
        7'b1001100,
        7'b0001101,
        7'b0001110,
        7'b1001111,
        7'b1010001,
        7'b1010010,
        7'b0010011,
        7'b1010100,
        7'b0010101,
        7'b0010110,
        7'b1010111,
        7'b1011000,
        7'b0011001,
        7'b0011010,
        7'b1011011,
        7'b0011100,
        7'b1011101,
        7'b1011110,
        7'b0011111,
        7'b1100001,
        7'b1100010,
        7'b0100011,
        7'b1100100,
        7'b0100101,
        7'b0100110,
        7'b1100111,
        7'b1101000,
        7'b0101001,
        7'b0101010
    };

    // each check bit is the parity of the data bits whose column has that bit set.
    function automatic parity_t ecc_encode(data_t d);
        parity_t p;
        p = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (d[i]) begin
                p = p ^ check_col[i];
            end
        end
        return p;
    endfunction

endpackage

`default_nettype wire

// ==== logic/ecc_36_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_36_top (
    input  wire ecc_pkg::data_t   data_in,
    input  wire ecc_pkg::parity_t parity_in,
    input  wire logic             bypass,
    output ecc_pkg::data_t        data_out,
    output ecc_pkg::parity_t      parity_out,
    output ecc_pkg::data_t        mask,
    output logic                  sbit_err,
    output logic                  dbit_err
);

    import ecc_pkg::*;

    parity_t    syndrome;
    logic       syn_zero;
    logic       data_hit;
    logic       check_hit;
    logic [1:0] error;

    // check bits as they should be for the data that was read back.
    assign parity_out = ecc_encode(data_in);
    assign syndrome   = parity_in ^ parity_out;

    // the columns are all distinct, so at most one data bit can match.
    always_comb begin
        mask = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (syndrome == check_col[i]) begin
                mask[i] = 1'b1;
            end
        end
    end

    assign syn_zero = (syndrome == '0);
    assign data_hit = |mask;

    // a lone syndrome bit points at the flipped check bit itself.
    assign check_hit = $onehot(syndrome);

    // error[0] marks a single error and error[1] a double error.
    always_comb begin
        error = 2'b00;
        if (data_hit || check_hit) begin
            error = 2'b01;
        end else if (!syn_zero) begin
            error = 2'b10;
        end
    end

    // Check bit errors leave the mask at zero so the data goes through untouched.
    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = bypass ? 1'b0 : error[0];
    assign dbit_err = bypass ? 1'b0 : error[1];

endmodule

`default_nettype wire

// ==== logic/ecc_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_ram (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           wr_en,
    input  wire ecc_pkg::addr_t wr_addr,
    input  wire ecc_pkg::data_t wr_data,
    input  wire ecc_pkg::code_t inject_mask,
    input  wire logic           rd_en,
    input  wire ecc_pkg::addr_t rd_addr,
    output ecc_pkg::code_t      rd_code,
    output logic                rd_valid,
    output ecc_pkg::addr_t      rd_addr_q
);

    import ecc_pkg::*;

    code_t mem [MEM_DEPTH];
    code_t wr_code;

    // check bits sit above the data, and the mask lets faults be planted.
    assign wr_code = {ecc_encode(wr_data), wr_data} ^ inject_mask;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_code;
        end
    end

    // a read of the address being written returns the old word.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_code   <= mem[rd_addr];
            rd_addr_q <= rd_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ecc_err_log.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_err_log (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           rd_valid,
    input  wire ecc_pkg::addr_t rd_addr_q,
    input  wire logic           sbit_err,
    input  wire logic           dbit_err,
    output ecc_pkg::count_t     sbit_count,
    output ecc_pkg::count_t     dbit_count,
    output ecc_pkg::addr_t      err_addr,
    output logic                err_addr_valid
);

    import ecc_pkg::*;

    // counts up by one and holds once all bits are set.
    function automatic count_t sat_inc(count_t c);
        count_t n;
        n = c;
        if (c != '1) begin
            n = c + count_t'(1);
        end
        return n;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sbit_count <= '0;
        end else if (rd_valid && sbit_err) begin
            sbit_count <= sat_inc(sbit_count);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dbit_count <= '0;
        end else if (rd_valid && dbit_err) begin
            dbit_count <= sat_inc(dbit_count);
        end
    end

    // the most recent faulty address wins.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_addr       <= '0;
            err_addr_valid <= 1'b0;
        end else if (rd_valid && (sbit_err || dbit_err)) begin
            err_addr       <= rd_addr_q;
            err_addr_valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ecc_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_top (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           wr_en,
    input  wire ecc_pkg::addr_t wr_addr,
    input  wire ecc_pkg::data_t wr_data,
    input  wire ecc_pkg::code_t inject_mask,
    input  wire logic           rd_en,
    input  wire ecc_pkg::addr_t rd_addr,
    input  wire logic           bypass,
    output logic                rd_valid,
    output ecc_pkg::data_t      rd_data,
    output logic                sbit_err,
    output logic                dbit_err,
    output ecc_pkg::count_t     sbit_count,
    output ecc_pkg::count_t     dbit_count,
    output ecc_pkg::addr_t      err_addr,
    output logic                err_addr_valid
);

    import ecc_pkg::*;

    code_t rd_code;
    addr_t rd_addr_q;

    ecc_ram ram_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .inject_mask (inject_mask),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_code     (rd_code),
        .rd_valid    (rd_valid),
        .rd_addr_q   (rd_addr_q)
    );

    // the decoder sits directly on the registered read word.
    ecc_36_top dec_i (
        .data_in    (rd_code[DATA_WIDTH-1:0]),
        .parity_in  (rd_code[CODE_WIDTH-1:DATA_WIDTH]),
        .bypass     (bypass),
        .data_out   (rd_data),
        .parity_out (),
        .mask       (),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    ecc_err_log log_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd_valid       (rd_valid),
        .rd_addr_q      (rd_addr_q),
        .sbit_err       (sbit_err),
        .dbit_err       (dbit_err),
        .sbit_count     (sbit_count),
        .dbit_count     (dbit_count),
        .err_addr       (err_addr),
        .err_addr_valid (err_addr_valid)
    );

endmodule

`default_nettype wire

// ==== tb/ecc_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_tb;

    import ecc_pkg::*;

    localparam string TEST_FILE = "tb/ecc_mem_tests.txt";

    logic   clk;
    logic   rst_n;
    logic   wr_en;
    addr_t  wr_addr;
    data_t  wr_data;
    code_t  inject_mask;
    logic   rd_en;
    addr_t  rd_addr;
    logic   bypass;
    logic   rd_valid;
    data_t  rd_data;
    logic   sbit_err;
    logic   dbit_err;
    count_t sbit_count;
    count_t dbit_count;
    addr_t  err_addr;
    logic   err_addr_valid;

    // one entry per line of the test file.
    string  t_name [$];
    string  t_op [$];
    addr_t  t_addr [$];
    data_t  t_data [$];
    code_t  t_mask [$];
    logic   t_bypass [$];
    data_t  t_exp_data [$];
    logic   t_exp_sbit [$];
    logic   t_exp_dbit [$];
    count_t t_exp_scount [$];
    count_t t_exp_dcount [$];
    addr_t  t_exp_eaddr [$];
    logic   t_exp_eav [$];

    // reads in flight, oldest first.
    string  p_name [$];
    data_t  p_data [$];
    logic   p_sbit [$];
    logic   p_dbit [$];
    int     p_due [$];

    int     cycle;
    int     limit;
    int     error_count;
    int     pass_count;
    int     fail_count;
    logic   bypass_next;

    ecc_mem_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .inject_mask    (inject_mask),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .bypass         (bypass),
        .rd_valid       (rd_valid),
        .rd_data        (rd_data),
        .sbit_err       (sbit_err),
        .dbit_err       (dbit_err),
        .sbit_count     (sbit_count),
        .dbit_count     (dbit_count),
        .err_addr       (err_addr),
        .err_addr_valid (err_addr_valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        @(posedge clk);
        while (limit == 0 || cycle < limit) begin
            @(posedge clk);
        end
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("Test FAILED");
        $finish;
    end

    task automatic load_tests(output logic ok);
        int     fd;
        int     code;
        string  line;
        string  name;
        string  op;
        addr_t  a;
        data_t  d;
        code_t  m;
        logic   b;
        data_t  ed;
        logic   es;
        logic   edb;
        count_t sc;
        count_t dc;
        addr_t  ea;
        logic   ev;
        ok = 1'b0;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("cannot open %s", TEST_FILE);
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line[0] != "#") begin
                    code = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h",
                                   name, op, a, d, m, b, ed, es, edb, sc, dc, ea, ev);
                    if (code == 13) begin
                        t_name.push_back(name);
                        t_op.push_back(op);
                        t_addr.push_back(a);
                        t_data.push_back(d);
                        t_mask.push_back(m);
                        t_bypass.push_back(b);
                        t_exp_data.push_back(ed);
                        t_exp_sbit.push_back(es);
                        t_exp_dbit.push_back(edb);
                        t_exp_scount.push_back(sc);
                        t_exp_dcount.push_back(dc);
                        t_exp_eaddr.push_back(ea);
                        t_exp_eav.push_back(ev);
                    end else if (code > 0) begin
                        $display("malformed line in %s: %s", TEST_FILE, line);
                        error_count++;
                    end
                end
            end
            $fclose(fd);
            ok = (t_name.size() > 0);
        end
    endtask

    // the decoder works in the cycle after the read strobe, so bypass trails it by one clock.
    task automatic step_clock();
        @(posedge clk);
        wr_en  <= 1'b0;
        rd_en  <= 1'b0;
        bypass <= bypass_next;
    endtask

    task automatic finish_test(string name, logic bad);
        if (bad) begin
            fail_count++;
            $display("FAIL %s", name);
        end else begin
            pass_count++;
            $display("PASS %s", name);
        end
    endtask

    task automatic drop_oldest_read();
        void'(p_name.pop_front());
        void'(p_data.pop_front());
        void'(p_sbit.pop_front());
        void'(p_dbit.pop_front());
        void'(p_due.pop_front());
    endtask

    task automatic drain_reads();
        while (p_name.size() != 0) begin
            step_clock();
        end
    endtask

    task automatic do_write(int i);
        step_clock();
        wr_en       <= 1'b1;
        wr_addr     <= t_addr[i];
        wr_data     <= t_data[i];
        inject_mask <= t_mask[i];
        finish_test(t_name[i], 1'b0);
    endtask

    task automatic do_read(int i);
        step_clock();
        rd_en       <= 1'b1;
        rd_addr     <= t_addr[i];
        bypass_next = t_bypass[i];
        p_name.push_back(t_name[i]);
        p_data.push_back(t_exp_data[i]);
        p_sbit.push_back(t_exp_sbit[i]);
        p_dbit.push_back(t_exp_dbit[i]);
        // rd_en is sampled at the next edge and rd_valid is seen after that one.
        p_due.push_back(cycle + 2);
    endtask

    // the log updates at the edge that closes the last rd_valid cycle.
    task automatic check_log(int i);
        logic bad;
        bad = 1'b0;
        step_clock();
        drain_reads();
        @(negedge clk);
        assert (sbit_count == t_exp_scount[i]) else begin
            $display("** Error %s: sbit_count expected %0d, actual %0d",
                     t_name[i], t_exp_scount[i], sbit_count);
            error_count++;
            bad = 1'b1;
        end
        assert (dbit_count == t_exp_dcount[i]) else begin
            $display("** Error %s: dbit_count expected %0d, actual %0d",
                     t_name[i], t_exp_dcount[i], dbit_count);
            error_count++;
            bad = 1'b1;
        end
        assert (err_addr == t_exp_eaddr[i]) else begin
            $display("** Error %s: err_addr expected %02h, actual %02h",
                     t_name[i], t_exp_eaddr[i], err_addr);
            error_count++;
            bad = 1'b1;
        end
        assert (err_addr_valid == t_exp_eav[i]) else begin
            $display("** Error %s: err_addr_valid expected %0b, actual %0b",
                     t_name[i], t_exp_eav[i], err_addr_valid);
            error_count++;
            bad = 1'b1;
        end
        finish_test(t_name[i], bad);
    endtask

    // read results are checked at the falling edge, in the middle of the rd_valid cycle.
    initial begin
        logic bad;
        forever begin
            @(negedge clk);
            if (rd_valid) begin
                if (p_name.size() == 0) begin
                    $display("rd_valid was high at cycle %0d with no read pending", cycle);
                    error_count++;
                end else begin
                    bad = 1'b0;
                    assert (p_due[0] == cycle) else begin
                        $display("read %s: rd_valid arrived at cycle %0d instead of %0d",
                                 p_name[0], cycle, p_due[0]);
                        error_count++;
                        bad = 1'b1;
                    end
                    assert (rd_data == p_data[0]) else begin
                        $display("** Error %s: rd_data expected %09h, actual %09h",
                                 p_name[0], p_data[0], rd_data);
                        error_count++;
                        bad = 1'b1;
                    end
                    assert (sbit_err == p_sbit[0]) else begin
                        $display("** Error %s: sbit_err expected %0b, actual %0b",
                                 p_name[0], p_sbit[0], sbit_err);
                        error_count++;
                        bad = 1'b1;
                    end
                    assert (dbit_err == p_dbit[0]) else begin
                        $display("** Error %s: dbit_err expected %0b, actual %0b",
                                 p_name[0], p_dbit[0], dbit_err);
                        error_count++;
                        bad = 1'b1;
                    end
                    finish_test(p_name[0], bad);
                    drop_oldest_read();
                end
            end else if (p_name.size() != 0 && p_due[0] <= cycle) begin
                $display("read %s: rd_valid did not arrive one cycle after rd_en", p_name[0]);
                error_count++;
                finish_test(p_name[0], 1'b1);
                drop_oldest_read();
            end
        end
    end

    initial begin
        logic  loaded;
        string prev_op;
        int    gap;
        rst_n       = 1'b0;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        inject_mask = '0;
        rd_en       = 1'b0;
        rd_addr     = '0;
        bypass      = 1'b0;
        bypass_next = 1'b0;
        limit       = 0;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        void'($urandom(3));
        load_tests(loaded);
        if (!loaded) begin
            $display("no tests could be read from %s", TEST_FILE);
            $display("Test FAILED");
            $finish;
        end else begin
            limit = 4 * t_name.size() + 100;
            repeat (10) begin
                step_clock();
            end
            rst_n <= 1'b1;
            prev_op = "";
            foreach (t_name[i]) begin
                // a read that follows a read goes out on the next clock, keeping the pipe full.
                if (!(t_op[i] == "R" && prev_op == "R")) begin
                    gap = $urandom_range(2, 0);
                    repeat (gap) begin
                        step_clock();
                    end
                end
                if (t_op[i] == "W") begin
                    do_write(i);
                end else if (t_op[i] == "R") begin
                    do_read(i);
                end else if (t_op[i] == "C") begin
                    check_log(i);
                end else begin
                    $display("test %s has an unknown operation %s", t_name[i], t_op[i]);
                    error_count++;
                    finish_test(t_name[i], 1'b1);
                end
                prev_op = t_op[i];
            end
            step_clock();
            drain_reads();
            @(negedge clk);
            $display("%0d tests: %0d passed, %0d failed, %0d errors",
                     t_name.size(), pass_count, fail_count, error_count);
            if (error_count == 0 && fail_count == 0 && pass_count == t_name.size()) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/ecc_pkg.sv
logic/ecc_36_top.sv
logic/ecc_ram.sv
logic/ecc_err_log.sv
logic/ecc_mem_top.sv
tb/ecc_mem_tb.sv

// ==== Makefile ====
# Verilator flow for the SECDED memory and its testbench.
TOP := ecc_mem_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timescale 1ns/1ps --top-module ecc_mem_top \
		logic/ecc_pkg.sv logic/ecc_36_top.sv logic/ecc_ram.sv \
		logic/ecc_err_log.sv logic/ecc_mem_top.sv
	verilator --lint-only --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f vlog.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// ==== tb/ecc_mem_tests.txt ====
# name op addr data mask bypass exp_data exp_sbit exp_dbit exp_scount exp_dcount exp_eaddr exp_eav
# all numbers hex; W stores data with mask applied, R checks the decoded read, C checks the log
c_reset       C 00 000000000 00000000000 0 000000000 0 0 0000 0000 00 0
w_clean_a     W 01 123456789 00000000000 0 000000000 0 0 0000 0000 00 0
w_clean_b     W 02 abcdef012 00000000000 0 000000000 0 0 0000 0000 00 0
w_clean_c     W 3f fffffffff 00000000000 0 000000000 0 0 0000 0000 00 0
r_clean_a     R 01 000000000 00000000000 0 123456789 0 0 0000 0000 00 0
r_clean_b     R 02 000000000 00000000000 0 abcdef012 0 0 0000 0000 00 0
r_clean_c     R 3f 000000000 00000000000 0 fffffffff 0 0 0000 0000 00 0
w_flip_d0     W 04 0f0f0f0f0 00000000001 0 000000000 0 0 0000 0000 00 0
w_flip_d17    W 05 555555555 00000020000 0 000000000 0 0 0000 0000 00 0
w_flip_d35    W 06 800000001 00800000000 0 000000000 0 0 0000 0000 00 0
r_flip_d0     R 04 000000000 00000000000 0 0f0f0f0f0 1 0 0000 0000 00 0
r_flip_d17    R 05 000000000 00000000000 0 555555555 1 0 0000 0000 00 0
r_flip_d35    R 06 000000000 00000000000 0 800000001 1 0 0000 0000 00 0
c_single      C 00 000000000 00000000000 0 000000000 0 0 0003 0000 06 1
w_flip_p0     W 07 13579bdf0 01000000000 0 000000000 0 0 0000 0000 00 0
w_flip_p6     W 08 2468ace02 40000000000 0 000000000 0 0 0000 0000 00 0
r_flip_p0     R 07 000000000 00000000000 0 13579bdf0 1 0 0000 0000 00 0
r_flip_p6     R 08 000000000 00000000000 0 2468ace02 1 0 0000 0000 00 0
w_dbl_d       W 09 0badc0ffe 00000000003 0 000000000 0 0 0000 0000 00 0
w_dbl_dp      W 0a 76543210f 10000000008 0 000000000 0 0 0000 0000 00 0
w_dbl_p       W 0b 000000000 03000000000 0 000000000 0 0 0000 0000 00 0
r_dbl_d       R 09 000000000 00000000000 0 0badc0ffd 0 1 0000 0000 00 0
r_dbl_dp      R 0a 000000000 00000000000 0 765432107 0 1 0000 0000 00 0
r_dbl_p       R 0b 000000000 00000000000 0 000000000 0 1 0000 0000 00 0
c_double      C 00 000000000 00000000000 0 000000000 0 0 0005 0003 0b 1
w_byp         W 0c 0cafe1234 00000000020 0 000000000 0 0 0000 0000 00 0
r_byp_single  R 0c 000000000 00000000000 1 0cafe1214 0 0 0000 0000 00 0
r_byp_double  R 0b 000000000 00000000000 1 000000000 0 0 0000 0000 00 0
c_bypass      C 00 000000000 00000000000 0 000000000 0 0 0005 0003 0b 1
r_fix_after   R 0c 000000000 00000000000 0 0cafe1234 1 0 0000 0000 00 0
w_rewrite     W 04 111111111 00000000000 0 000000000 0 0 0000 0000 00 0
r_rewrite     R 04 000000000 00000000000 0 111111111 0 0 0000 0000 00 0
r_clean_b2    R 02 000000000 00000000000 0 abcdef012 0 0 0000 0000 00 0
c_final       C 00 000000000 00000000000 0 000000000 0 0 0006 0003 0c 1
